//--- branch_ctrl_top.f
+incdir+.
branch_ctrl_pkg.sv
branch_ctrl_itf.sv
branch_resolver.sv
control_buffer.sv
branch_commit.sv
branch_ctrl_top.sv
tb_branch_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_branch_ctrl
LINT_TOP  ?= branch_ctrl_top
FILELIST  ?= branch_ctrl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_branch_ctrl.sv
`timescale 1ns/1ps
`include "branch_ctrl_config.svh"

module tb_branch_ctrl;

    localparam int NUM_TESTS  = 6;
    localparam int PRED_RIGHT = 2;
    localparam int PRED_WRONG = 3;

    logic clk, rst;
    logic alloc_valid, alloc_ready, issue_valid, issue_pred_taken;
    logic rob_head_valid, retire_valid, redirect_valid;
    logic [`ROB_IDX_W-1:0] alloc_rob_id, issue_rob_id, rob_head_id, retire_rob_id;
    logic [`ADDR_W-1:0] issue_src_a, issue_src_b, issue_pc, issue_offset, redirect_target;
    branch_ctrl_pkg::br_op_t issue_op;

    integer seed;
    logic [`ROB_IDX_W-1:0] next_id;
    logic [`ROB_IDX_W-1:0] rob_q [$];                  // outstanding ids in allocation order
    logic                  exp_mis [1 << `ROB_IDX_W];
    logic [`ADDR_W-1:0]    exp_tgt [1 << `ROB_IDX_W];

    branch_ctrl_top dut_i (.*);

    always #20 clk = ~clk;

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    initial begin
        #(NUM_TESTS * 400 * 40);
        $display("watchdog expired before the tests finished");
        stop_with_failure();
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %s: expected %0h, actual %0h", name, exp, act);
            stop_with_failure();
        end
    endtask

    function automatic logic branch_taken(input branch_ctrl_pkg::br_op_t op,
                                          input logic [`ADDR_W-1:0] a, b);
        case (op)
            branch_ctrl_pkg::BR_EQ:  return a == b;
            branch_ctrl_pkg::BR_NE:  return a != b;
            branch_ctrl_pkg::BR_LT:  return $signed(a) < $signed(b);
            branch_ctrl_pkg::BR_GE:  return $signed(a) >= $signed(b);
            branch_ctrl_pkg::BR_LTU: return a < b;
            default:                 return a >= b;     // BR_GEU
        endcase
    endfunction

    task automatic alloc(input string name, output logic [`ROB_IDX_W-1:0] id);
        id = next_id;
        next_id = next_id + 1'b1;
        @(negedge clk);
        check(name, 64'(1'b1), 64'(alloc_ready));
        alloc_valid  = 1'b1;
        alloc_rob_id = id;
        @(negedge clk);
        alloc_valid = 1'b0;
        rob_q.push_back(id);
    endtask

    // pred_mode is 0 or 1 for a fixed prediction, else PRED_RIGHT or PRED_WRONG
    task automatic resolve(input logic [`ROB_IDX_W-1:0] id,
                           input branch_ctrl_pkg::br_op_t op, input int pred_mode);
        logic [31:0] r;
        logic        taken;
        r = $random(seed);
        @(negedge clk);
        issue_valid  = 1'b1;
        issue_rob_id = id;
        issue_op     = op;
        issue_src_a  = $random(seed);
        issue_src_b  = r[0] ? issue_src_a : $random(seed);   // equal operands now and then
        issue_pc     = $random(seed);
        issue_offset = $random(seed);
        taken = branch_taken(op, issue_src_a, issue_src_b);
        issue_pred_taken = (pred_mode == PRED_RIGHT) ? taken :
                           (pred_mode == PRED_WRONG) ? !taken : pred_mode[0];
        exp_mis[id] = (taken != issue_pred_taken);
        exp_tgt[id] = taken ? issue_pc + issue_offset : issue_pc + `ADDR_W'd4;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    // rob head model that presents the oldest id until it retires
    task automatic retire_head(input string name);
        logic [`ROB_IDX_W-1:0] id;
        id = rob_q.pop_front();
        @(negedge clk);
        rob_head_valid = 1'b1;
        rob_head_id    = id;
        for (int n = 0; !retire_valid; n++) begin
            if (n == 50) begin
                $display("%s: branch %0d did not retire within 50 cycles", name, id);
                stop_with_failure();
            end
            @(negedge clk);
        end
        rob_head_valid = 1'b0;
        check(name, 64'(id), 64'(retire_rob_id));
        check(name, 64'(exp_mis[id]), 64'(redirect_valid));
        if (exp_mis[id]) begin
            check(name, 64'(exp_tgt[id]), 64'(redirect_target));
            rob_q.delete();                             // everything younger is flushed
        end
    endtask

    task automatic expect_no_retire(input string name, input logic [`ROB_IDX_W-1:0] id);
        @(negedge clk);
        rob_head_valid = 1'b1;
        rob_head_id    = id;
        repeat (10) begin
            @(negedge clk);
            check(name, 64'(1'b0), 64'(retire_valid));
        end
    endtask

    task automatic reset_state();
        check("reset_state", 64'(1'b1), 64'(alloc_ready));
        check("reset_state", 64'(1'b0), 64'(retire_valid));
        check("reset_state", 64'(1'b0), 64'(redirect_valid));
    endtask

    task automatic in_order_retire();
        logic [`ROB_IDX_W-1:0] ids [3];
        for (int i = 0; i < 3; i++) begin
            alloc("in_order", ids[i]);
        end
        for (int i = 2; i >= 0; i--) begin
            resolve(ids[i], branch_ctrl_pkg::BR_LTU, PRED_RIGHT);
        end
        repeat (3) begin
            retire_head("in_order");
        end
    endtask

    task automatic full_buffer();
        logic [`ROB_IDX_W-1:0] id;
        repeat (`CB_DEPTH) begin
            alloc("full", id);
            resolve(id, branch_ctrl_pkg::BR_NE, PRED_RIGHT);
        end
        check("full", 64'(1'b0), 64'(alloc_ready));
        retire_head("full");
        check("full", 64'(1'b1), 64'(alloc_ready));
        while (rob_q.size() > 0) begin
            retire_head("full");
        end
    endtask

    task automatic head_unresolved();
        logic [`ROB_IDX_W-1:0] id;
        alloc("head_unresolved", id);
        expect_no_retire("head_unresolved", id);    // head stays presented
        resolve(id, branch_ctrl_pkg::BR_GE, PRED_RIGHT);
        retire_head("head_unresolved");
    endtask

    task automatic mispredict_flush();
        logic [`ROB_IDX_W-1:0] id0;
        logic [`ROB_IDX_W-1:0] id1;
        alloc("mispredict", id0);
        alloc("mispredict", id1);
        resolve(id0, branch_ctrl_pkg::BR_LT, PRED_WRONG);
        resolve(id1, branch_ctrl_pkg::BR_EQ, PRED_RIGHT);
        retire_head("mispredict");
        check("mispredict", 64'(1'b1), 64'(redirect_valid));
        expect_no_retire("mispredict", id1);
        rob_head_valid = 1'b0;
        check("mispredict", 64'(1'b1), 64'(alloc_ready));
    endtask

    task automatic op_sweep();
        branch_ctrl_pkg::br_op_t op;
        logic [`ROB_IDX_W-1:0]   id;
        for (int k = 0; k < 6; k++) begin
            op = branch_ctrl_pkg::br_op_t'(k[2:0]);
            for (int p = 0; p < 2; p++) begin
                alloc("op_sweep", id);
                resolve(id, op, p);
                retire_head($sformatf("op_sweep %s pred %0d", op.name(), p));
            end
        end
    endtask

    initial begin
        seed    = 7;
        next_id = '0;
        clk     = 1'b0;
        rst     = 1'b1;
        issue_op = branch_ctrl_pkg::BR_EQ;
        {alloc_valid, alloc_rob_id, issue_valid, issue_rob_id, issue_src_a, issue_src_b,
         issue_pc, issue_offset, issue_pred_taken, rob_head_valid, rob_head_id} = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_state();
        in_order_retire();
        full_buffer();
        head_unresolved();
        mispredict_flush();
        op_sweep();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- branch_ctrl_top.sv
`timescale 1ns/1ps
`include "branch_ctrl_config.svh"

module branch_ctrl_top (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     alloc_valid,
    input  logic [`ROB_IDX_W-1:0]    alloc_rob_id,
    output logic                     alloc_ready,

    input  logic                     issue_valid,
    input  logic [`ROB_IDX_W-1:0]    issue_rob_id,
    input  branch_ctrl_pkg::br_op_t  issue_op,
    input  logic [`ADDR_W-1:0]       issue_src_a,
    input  logic [`ADDR_W-1:0]       issue_src_b,
    input  logic [`ADDR_W-1:0]       issue_pc,
    input  logic [`ADDR_W-1:0]       issue_offset,
    input  logic                     issue_pred_taken,

    input  logic                     rob_head_valid,
    input  logic [`ROB_IDX_W-1:0]    rob_head_id,

    output logic                     retire_valid,
    output logic [`ROB_IDX_W-1:0]    retire_rob_id,
    output logic                     redirect_valid,
    output logic [`ADDR_W-1:0]       redirect_target
);

    ds_cb_itf  ds_cb ();
    br_cdb_itf br_cdb ();
    cb_rob_itf cb_rob ();

    // dispatch side comes straight from the ports
    assign ds_cb.valid  = alloc_valid;
    assign ds_cb.rob_id = alloc_rob_id;
    assign alloc_ready  = ds_cb.ready;

    branch_resolver resolver_i (
        .clk              (clk),
        .rst              (rst),
        .flush            (cb_rob.flush),
        .issue_valid      (issue_valid),
        .issue_rob_id     (issue_rob_id),
        .issue_op         (issue_op),
        .issue_src_a      (issue_src_a),
        .issue_src_b      (issue_src_b),
        .issue_pc         (issue_pc),
        .issue_offset     (issue_offset),
        .issue_pred_taken (issue_pred_taken),
        .cdb              (br_cdb.res)
    );

    control_buffer cb_i (
        .clk       (clk),
        .rst       (rst),
        .from_ds   (ds_cb.cb),
        .br_cdb_in (br_cdb.cb),
        .to_rob    (cb_rob.cb)
    );

    branch_commit commit_i (
        .clk             (clk),
        .rst             (rst),
        .rob_head_valid  (rob_head_valid),
        .rob_head_id     (rob_head_id),
        .to_cb           (cb_rob.cm),
        .retire_valid    (retire_valid),
        .retire_rob_id   (retire_rob_id),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target)
    );

endmodule

//--- branch_commit.sv
`timescale 1ns/1ps
`include "branch_ctrl_config.svh"

module branch_commit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rob_head_valid,
    input  logic [`ROB_IDX_W-1:0] rob_head_id,
    cb_rob_itf.cm                 to_cb,
    output logic                  retire_valid,
    output logic [`ROB_IDX_W-1:0] retire_rob_id,
    output logic                  redirect_valid,
    output logic [`ADDR_W-1:0]    redirect_target
);

    logic retire_now;

    // head must be resolved and be the oldest instruction in the ROB
    assign retire_now = to_cb.head_valid && to_cb.head_ready && rob_head_valid &&
                        (rob_head_id == to_cb.head.rob_id);

    assign to_cb.dequeue = retire_now;
    assign to_cb.flush   = retire_now && to_cb.head.mispredict;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            retire_valid   <= retire_now;
            redirect_valid <= to_cb.flush;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_now) begin
            retire_rob_id   <= to_cb.head.rob_id;
            redirect_target <= to_cb.head.target;
        end
    end

    a_redirect_retire: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> retire_valid)
        else $error("branch_commit: redirect without retire");

    // buffer must come back empty after a flush
    a_flush_empty: assert property (@(posedge clk) disable iff (rst)
        to_cb.flush |=> !to_cb.head_valid)
        else $error("branch_commit: buffer not empty after flush");

endmodule

//--- control_buffer.sv
`timescale 1ns/1ps
`include "branch_ctrl_config.svh"

module control_buffer (
    input  logic    clk,
    input  logic    rst,
    ds_cb_itf.cb    from_ds,
    br_cdb_itf.cb   br_cdb_in,
    cb_rob_itf.cb   to_rob
);

    localparam int CB_IDX = $clog2(`CB_DEPTH);

    branch_ctrl_pkg::br_result_t ent_res [`CB_DEPTH];
    logic [`CB_DEPTH-1:0]        ent_valid;
    logic [`CB_DEPTH-1:0]        ent_ready;   // outcome received
    logic [`CB_DEPTH-1:0]        hit;

    logic [CB_IDX:0]   wr_ptr;
    logic [CB_IDX:0]   rd_ptr;
    logic [CB_IDX-1:0] wr_idx;
    logic [CB_IDX-1:0] rd_idx;
    logic              full;
    logic              empty;
    logic              enqueue;
    logic              dequeue;
    logic              flush;

    assign wr_idx = wr_ptr[CB_IDX-1:0];
    assign rd_idx = rd_ptr[CB_IDX-1:0];

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_idx == rd_idx) && (wr_ptr[CB_IDX] != rd_ptr[CB_IDX]);

    assign from_ds.ready = ~full;
    assign enqueue       = from_ds.valid && ~full;
    assign dequeue       = to_rob.dequeue;
    assign flush         = to_rob.flush;

    always_comb begin
        for (int i = 0; i < `CB_DEPTH; i++) begin
            hit[i] = br_cdb_in.valid && ent_valid[i] &&
                     (ent_res[i].rob_id == br_cdb_in.result.rob_id);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            ent_valid <= '0;
            ent_ready <= '0;
        end else begin
            for (int i = 0; i < `CB_DEPTH; i++) begin
                if (hit[i]) begin
                    ent_ready[i] <= 1'b1;
                end
            end
            if (dequeue) begin
                ent_valid[rd_idx] <= 1'b0;
                rd_ptr            <= rd_ptr + 1'b1;
            end
            if (enqueue) begin
                ent_valid[wr_idx] <= 1'b1;
                ent_ready[wr_idx] <= 1'b0;
                wr_ptr            <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CB_DEPTH; i++) begin
            if (hit[i]) begin
                ent_res[i].mispredict <= br_cdb_in.result.mispredict;
                ent_res[i].target     <= br_cdb_in.result.target;
            end
        end
        if (enqueue) begin
            ent_res[wr_idx].rob_id <= from_ds.rob_id;
        end
    end

    assign to_rob.head_valid = ~empty;
    assign to_rob.head_ready = ent_ready[rd_idx];
    assign to_rob.head       = ent_res[rd_idx];

    // a live entry at the write slot means the buffer is full
    a_no_enq_full: assert property (@(posedge clk) disable iff (rst)
        enqueue |-> !ent_valid[wr_idx])
        else $error("control_buffer: write while full");

    a_no_deq_empty: assert property (@(posedge clk) disable iff (rst)
        dequeue |-> !empty)
        else $error("control_buffer: dequeue while empty");

    a_one_hit: assert property (@(posedge clk) disable iff (rst)
        $onehot0(hit))
        else $error("control_buffer: result matches several entries");

endmodule

//--- branch_resolver.sv
`timescale 1ns/1ps
`include "branch_ctrl_config.svh"

module branch_resolver (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     issue_valid,
    input  logic [`ROB_IDX_W-1:0]    issue_rob_id,
    input  branch_ctrl_pkg::br_op_t  issue_op,
    input  logic [`ADDR_W-1:0]       issue_src_a,
    input  logic [`ADDR_W-1:0]       issue_src_b,
    input  logic [`ADDR_W-1:0]       issue_pc,
    input  logic [`ADDR_W-1:0]       issue_offset,
    input  logic                     issue_pred_taken,
    br_cdb_itf.res                   cdb
);

    logic                        taken;
    branch_ctrl_pkg::br_result_t res_d;

    always_comb begin
        case (issue_op)
            branch_ctrl_pkg::BR_EQ:  taken = (issue_src_a == issue_src_b);
            branch_ctrl_pkg::BR_NE:  taken = (issue_src_a != issue_src_b);
            branch_ctrl_pkg::BR_LT:  taken = ($signed(issue_src_a) < $signed(issue_src_b));
            branch_ctrl_pkg::BR_GE:  taken = ($signed(issue_src_a) >= $signed(issue_src_b));
            branch_ctrl_pkg::BR_LTU: taken = (issue_src_a < issue_src_b);
            branch_ctrl_pkg::BR_GEU: taken = (issue_src_a >= issue_src_b);
            default:                 taken = 1'b0;
        endcase
    end

    always_comb begin
        res_d.rob_id     = issue_rob_id;
        res_d.mispredict = (taken != issue_pred_taken);
        res_d.target     = taken ? (issue_pc + issue_offset) : (issue_pc + `ADDR_W'd4);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else if (flush) begin
            cdb.valid <= 1'b0;      // drop in-flight result
        end else begin
            cdb.valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb.result <= res_d;
        end
    end

    a_legal_op: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> issue_op inside {branch_ctrl_pkg::BR_EQ, branch_ctrl_pkg::BR_NE,
                                         branch_ctrl_pkg::BR_LT, branch_ctrl_pkg::BR_GE,
                                         branch_ctrl_pkg::BR_LTU, branch_ctrl_pkg::BR_GEU})
        else $error("branch_resolver: illegal opcode %0d", issue_op);

endmodule

//--- branch_ctrl_itf.sv
`timescale 1ns/1ps
`include "branch_ctrl_config.svh"

interface ds_cb_itf;
    logic                  valid;
    logic                  ready;
    logic [`ROB_IDX_W-1:0] rob_id;

    modport ds (
        output valid,
        output rob_id,
        input  ready
    );

    modport cb (
        input  valid,
        input  rob_id,
        output ready
    );
endinterface

interface br_cdb_itf;
    logic                       valid;   // one pulse per resolved branch
    branch_ctrl_pkg::br_result_t result;

    modport res (output valid, output result);

    modport cb (input valid, input result);
endinterface

interface cb_rob_itf;
    logic                       head_valid;
    logic                       head_ready;
    branch_ctrl_pkg::br_result_t head;
    logic                       dequeue;
    logic                       flush;

    modport cb (
        output head_valid,
        output head_ready,
        output head,
        input  dequeue,
        input  flush
    );

    modport cm (
        input  head_valid,
        input  head_ready,
        input  head,
        output dequeue,
        output flush
    );
endinterface

//--- branch_ctrl_pkg.sv
`include "branch_ctrl_config.svh"

package branch_ctrl_pkg;

    typedef enum logic [2:0] {
        BR_EQ  = 3'd0,
        BR_NE  = 3'd1,
        BR_LT  = 3'd2,          // signed
        BR_GE  = 3'd3,          // signed
        BR_LTU = 3'd4,
        BR_GEU = 3'd5
    } br_op_t;

    typedef struct packed {
        logic [`ROB_IDX_W-1:0] rob_id;
        logic                  mispredict;
        logic [`ADDR_W-1:0]    target;     // correct next pc
    } br_result_t;

endpackage

//--- branch_ctrl_config.svh
`ifndef BRANCH_CTRL_CONFIG_SVH
`define BRANCH_CTRL_CONFIG_SVH

// control buffer entries (power of two)
`define CB_DEPTH 4

`define ROB_IDX_W 5

`define ADDR_W 32

`endif
